/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_wbx2_top
FLIST     ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

SRCS := $(wildcard hw/*.sv hw/*.svh dv/*.sv)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST OK" $(LOG) || { echo "simulation ended without verdict"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/tb_clk_gen.sv */
module tb_clk_gen #(
	parameter int HALF_PERIOD  = 4,
	parameter int RESET_CYCLES = 16
) (
	output logic clk_x2,
	output logic reset
);

	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clk_x2 = 1'b0;
		forever #(HALF_PERIOD) clk_x2 = !clk_x2;
	end

	// reset drops on a falling edge like every other input
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_x2);
		@(negedge clk_x2);
		reset = 1'b0;
	end

endmodule

/* dv/tb_wbx2_top.sv */
`include "wbx2_params.svh"

module tb_wbx2_top;

	timeunit 1ns;
	timeprecision 1ps;

	// upper bound on wide accesses over all tests
	// each access fits well inside 64 cycles
	localparam int ACCESS_BOUND = 96;
	localparam int CYCLE_LIMIT  = ACCESS_BOUND * 64;

	logic                   clk_x2;
	logic                   reset;
	logic                   phase;
	wbx2_pkg::endian_e      endian;
	wbx2_pkg::wb_wide_req_t wide_req;
	wbx2_pkg::wb_wide_rsp_t wide_rsp;

	int          errors = 0;
	int          checks = 0;
	int          tests  = 0;
	int          cycles = 0;
	int          seed   = 32'ha37c83d6;
	logic [15:0] ref_mem [`WBX2_RAM_DEPTH];

	tb_clk_gen clk_gen_i (
		.clk_x2 (clk_x2),
		.reset  (reset)
	);

	wbx2_top dut_i (
		.clk_x2     (clk_x2),
		.reset      (reset),
		.endian_i   (endian),
		.wide_req_i (wide_req),
		.wide_rsp_o (wide_rsp),
		.phase_o    (phase)
	);

	always @(posedge clk_x2) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: run still busy after %0d cycles", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	// --------------------------------------------------
	// compare tasks
	// --------------------------------------------------
	task automatic compare_wide_rsp(input string name, input wbx2_pkg::wb_wide_rsp_t got,
		input wbx2_pkg::wb_wide_rsp_t exp, input logic check_dat);
		checks++;
		if (got.ack !== exp.ack || (check_dat && got.dat !== exp.dat)) begin
			errors++;
			$display("[FAIL] %s: dat=%h ack=%h, expected dat=%h ack=%h",
				name, got.dat, got.ack, exp.dat, exp.ack);
		end
	endtask

	task automatic compare_phase(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		tests++;
		$display("%-20s %s", name, (errors == errs_before) ? "passed" : "failed");
	endtask

	// --------------------------------------------------
	// reference memory of half-words
	// --------------------------------------------------
	function automatic int half_index(input logic [29:0] adr, input logic beat);
		return int'({1'b0, adr, beat} % `WBX2_RAM_DEPTH);
	endfunction

	// big endian sends the high data and sel half to the even half-word
	function automatic void update_ref(input logic [29:0] adr, input logic [31:0] dat,
		input logic [3:0] sel, input wbx2_pkg::endian_e end_v);
		int idx;
		int lane;
		for (int beat = 0; beat < 2; beat++) begin
			lane = (end_v == wbx2_pkg::ENDIAN_BIG) ? 1 - beat : beat;
			idx  = half_index(adr, beat[0]);
			for (int b = 0; b < 2; b++) begin
				if (sel[lane*2+b]) begin
					ref_mem[idx][b*8 +: 8] = dat[lane*16+b*8 +: 8];
				end
			end
		end
	endfunction

	function automatic logic [31:0] expect_word(input logic [29:0] adr,
		input wbx2_pkg::endian_e end_v);
		logic [15:0] even_h;
		logic [15:0] odd_h;
		even_h = ref_mem[half_index(adr, 1'b0)];
		odd_h  = ref_mem[half_index(adr, 1'b1)];
		return (end_v == wbx2_pkg::ENDIAN_BIG) ? {even_h, odd_h} : {odd_h, even_h};
	endfunction

	// --------------------------------------------------
	// one wide access with its ack window checked
	// --------------------------------------------------
	task automatic run_access(input logic we, input logic [29:0] adr, input logic [31:0] dat,
		input logic [3:0] sel, input wbx2_pkg::endian_e end_v,
		output wbx2_pkg::wb_wide_rsp_t rsp_rise,
		output wbx2_pkg::wb_wide_rsp_t rsp_held);
		wbx2_pkg::wb_wide_rsp_t ack_only;
		ack_only     = '0;
		ack_only.ack = 1'b1;
		@(negedge clk_x2);
		while (phase !== 1'b0) @(negedge clk_x2);
		wide_req.adr = adr;
		wide_req.dat = dat;
		wide_req.we  = we;
		wide_req.sel = sel;
		wide_req.stb = 1'b1;
		endian       = end_v;
		@(negedge clk_x2);
		while (wide_rsp.ack !== 1'b1) @(negedge clk_x2);
		rsp_rise = wide_rsp;
		compare_phase("phase_o at ack rise", phase, 1'b0);
		@(negedge clk_x2);
		rsp_held = wide_rsp;
		compare_wide_rsp("wide_rsp_o.ack in second ack cycle", wide_rsp, ack_only, 1'b0);
		compare_phase("phase_o in second ack cycle", phase, 1'b1);
		wide_req.stb = 1'b0;
		@(negedge clk_x2);
		compare_wide_rsp("wide_rsp_o.ack after window", wide_rsp, '0, 1'b0);
	endtask

	task automatic write_word(input logic [29:0] adr, input logic [31:0] dat,
		input logic [3:0] sel, input wbx2_pkg::endian_e end_v);
		wbx2_pkg::wb_wide_rsp_t rsp_rise;
		wbx2_pkg::wb_wide_rsp_t rsp_held;
		run_access(1'b1, adr, dat, sel, end_v, rsp_rise, rsp_held);
		update_ref(adr, dat, sel, end_v);
	endtask

	task automatic read_check(input string name, input logic [29:0] adr,
		input wbx2_pkg::endian_e end_v, input logic [31:0] exp_dat);
		wbx2_pkg::wb_wide_rsp_t rsp_rise;
		wbx2_pkg::wb_wide_rsp_t rsp_held;
		wbx2_pkg::wb_wide_rsp_t exp;
		run_access(1'b0, adr, 32'h0, 4'hf, end_v, rsp_rise, rsp_held);
		exp.dat = exp_dat;
		exp.ack = 1'b1;
		compare_wide_rsp(name, rsp_rise, exp, 1'b1);
		compare_wide_rsp({name, " second ack cycle"}, rsp_held, exp, 1'b1);
	endtask

	// --------------------------------------------------
	// directed tests
	// --------------------------------------------------
	task automatic test_reset();
		int e0;
		e0 = errors;
		repeat (2) @(negedge clk_x2);
		compare_phase("phase_o in reset", phase, 1'b0);
		while (reset !== 1'b0) @(posedge clk_x2);
		// cycle 0 is the one in which reset drops
		for (int k = 1; k <= 8; k++) begin
			@(negedge clk_x2);
			compare_phase("phase_o after reset", phase, k[0]);
			compare_wide_rsp("wide_rsp_o.ack after reset", wide_rsp, '0, 1'b0);
		end
		report_test("reset", e0);
	endtask

	task automatic test_little_round_trip();
		int e0;
		e0 = errors;
		write_word(30'h3, 32'h1234_5678, 4'hf, wbx2_pkg::ENDIAN_LITTLE);
		read_check("wide_rsp_o.dat little", 30'h3, wbx2_pkg::ENDIAN_LITTLE, 32'h1234_5678);
		report_test("little round trip", e0);
	endtask

	task automatic test_big_mapping();
		int e0;
		e0 = errors;
		write_word(30'h5, 32'haabb_ccdd, 4'hf, wbx2_pkg::ENDIAN_LITTLE);
		read_check("wide_rsp_o.dat big", 30'h5, wbx2_pkg::ENDIAN_BIG, 32'hccdd_aabb);
		report_test("big endian mapping", e0);
	endtask

	task automatic test_partial_sel();
		int e0;
		e0 = errors;
		write_word(30'h9, 32'h1122_3344, 4'hf, wbx2_pkg::ENDIAN_LITTLE);
		write_word(30'h9, 32'hffff_bbbb, 4'b0011, wbx2_pkg::ENDIAN_LITTLE);
		read_check("wide_rsp_o.dat sel 0011", 30'h9, wbx2_pkg::ENDIAN_LITTLE, 32'h1122_bbbb);
		write_word(30'h9, 32'hcccc_ffff, 4'b1100, wbx2_pkg::ENDIAN_LITTLE);
		read_check("wide_rsp_o.dat sel 1100", 30'h9, wbx2_pkg::ENDIAN_LITTLE, 32'hcccc_bbbb);
		write_word(30'h9, 32'h00ee_0000, 4'b0100, wbx2_pkg::ENDIAN_LITTLE);
		read_check("wide_rsp_o.dat sel 0100", 30'h9, wbx2_pkg::ENDIAN_LITTLE, 32'hccee_bbbb);
		// low lanes in big endian land on the odd half-word
		write_word(30'h9, 32'h0000_9999, 4'b0011, wbx2_pkg::ENDIAN_BIG);
		read_check("wide_rsp_o.dat big 0011", 30'h9, wbx2_pkg::ENDIAN_LITTLE, 32'h9999_bbbb);
		report_test("partial selects", e0);
	endtask

	task automatic test_ack_alignment();
		int e0;
		e0 = errors;
		for (int gap = 0; gap < 4; gap++) begin
			repeat (gap) @(negedge clk_x2);
			read_check("wide_rsp_o.dat spaced", 30'h9, wbx2_pkg::ENDIAN_LITTLE,
				expect_word(30'h9, wbx2_pkg::ENDIAN_LITTLE));
		end
		report_test("ack alignment", e0);
	endtask

	task automatic test_random();
		int                e0;
		logic [31:0]       rnd;
		logic [31:0]       dat;
		logic [29:0]       adr;
		wbx2_pkg::endian_e rd_end;
		e0 = errors;
		// full words first so every read byte is defined
		for (int a = 0; a < 8; a++) begin
			rnd = $random(seed);
			dat = $random(seed);
			write_word(30'(a), dat, 4'hf, wbx2_pkg::endian_e'(rnd[0]));
		end
		for (int n = 0; n < 32; n++) begin
			rnd    = $random(seed);
			dat    = $random(seed);
			adr    = {27'b0, rnd[2:0]};
			rd_end = wbx2_pkg::endian_e'(rnd[8]);
			write_word(adr, dat, rnd[6:3], wbx2_pkg::endian_e'(rnd[7]));
			read_check("wide_rsp_o.dat random", adr, rd_end, expect_word(adr, rd_end));
		end
		report_test("random traffic", e0);
	endtask

	initial begin
		wide_req = '0;
		endian   = wbx2_pkg::ENDIAN_LITTLE;
		test_reset();
		test_little_round_trip();
		test_big_mapping();
		test_partial_sel();
		test_ack_alignment();
		test_random();
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* hw/wbx2_beat_fsm.sv */
module wbx2_beat_fsm (
	input  logic       clk_x2,
	input  logic       reset,
	input  logic       wide_stb_i,
	input  logic [1:0] beat_sel_i,
	input  logic       half_ack_i,
	output logic       beat_o,
	output logic       half_stb_o,
	output logic       wide_ack_o,
	output logic       phase_o
);

	logic                  phase_q;
	logic                  hold_ack_q;
	logic                  beat_live;
	logic                  beat_done;
	wbx2_pkg::beat_state_e state_q;
	wbx2_pkg::beat_state_e state_d;

	// ------------------------------------------------
	// slow clock phase, 0 is the first half
	// ------------------------------------------------
	always_ff @(posedge clk_x2) begin
		if (reset) begin
			phase_q <= 1'b0;
		end else begin
			phase_q <= !phase_q;
		end
	end

	// empty lanes mean nothing to move in this beat
	assign beat_live = |beat_sel_i;
	assign beat_done = !beat_live || half_ack_i;

	// ------------------------------------------------
	// beat sequencing
	// ------------------------------------------------
	always_comb begin
		state_d = state_q;
		case (state_q)
			wbx2_pkg::BEAT_IDLE: begin
				// accept only on phase 0, skip an empty beat 0 right away
				if (wide_stb_i && !phase_q) begin
					state_d = beat_live ? wbx2_pkg::BEAT_FIRST : wbx2_pkg::BEAT_SECOND;
				end
			end
			wbx2_pkg::BEAT_FIRST: begin
				if (beat_done) begin
					state_d = wbx2_pkg::BEAT_SECOND;
				end
			end
			wbx2_pkg::BEAT_SECOND: begin
				if (beat_done) begin
					state_d = wbx2_pkg::BEAT_HOLD;
				end
			end
			wbx2_pkg::BEAT_HOLD: begin
				// leave after the phase 1 ack cycle
				if (hold_ack_q) begin
					state_d = wbx2_pkg::BEAT_IDLE;
				end
			end
			default: state_d = wbx2_pkg::BEAT_IDLE;
		endcase
	end

	always_ff @(posedge clk_x2) begin
		if (reset) begin
			state_q    <= wbx2_pkg::BEAT_IDLE;
			hold_ack_q <= 1'b0;
		end else begin
			state_q    <= state_d;
			// marks that the phase 0 ack cycle has gone by
			hold_ack_q <= (state_q == wbx2_pkg::BEAT_HOLD) && !phase_q;
		end
	end

	assign beat_o     = (state_q == wbx2_pkg::BEAT_SECOND);
	assign half_stb_o = ((state_q == wbx2_pkg::BEAT_FIRST) ||
		(state_q == wbx2_pkg::BEAT_SECOND)) && beat_live;
	// ack spans one whole slow cycle, phase 0 then phase 1
	assign wide_ack_o = (state_q == wbx2_pkg::BEAT_HOLD) && (!phase_q || hold_ack_q);
	assign phase_o    = phase_q;

	// wide ack starts in hold on phase 0 and lasts exactly two cycles
	a_wide_ack_window: assert property (@(posedge clk_x2) disable iff (reset)
		$rose(wide_ack_o) |-> (state_q == wbx2_pkg::BEAT_HOLD) && !phase_q
			##1 wide_ack_o && (state_q == wbx2_pkg::BEAT_HOLD) ##1 !wide_ack_o);

	// beat stb stays in its beat state until the RAM acks
	a_half_stb_held: assert property (@(posedge clk_x2) disable iff (reset)
		half_stb_o && !half_ack_i |=> half_stb_o && (state_q == $past(state_q)));

endmodule

/* hw/wbx2_half_ram.sv */
`include "wbx2_params.svh"

module wbx2_half_ram (
	input  logic                   clk_x2,
	input  logic                   reset,
	input  wbx2_pkg::wb_half_req_t half_req_i,
	output wbx2_pkg::wb_half_rsp_t half_rsp_o
);

	localparam int IDX_W = $clog2(`WBX2_RAM_DEPTH);
	localparam int BYTES = `WBX2_HALF_DAT_W / 8;

	logic [`WBX2_HALF_DAT_W-1:0] mem_q [`WBX2_RAM_DEPTH];
	logic [IDX_W-1:0]            idx;
	logic                        timer_busy;
	logic                        timer_expired;
	logic                        beat_start;
	logic                        beat_last;

	// upper address bits fold onto the small array
	assign idx = half_req_i.adr[IDX_W-1:0];

	// ------------------------------------------------
	// wait state pacing
	// ------------------------------------------------
	assign beat_start = half_req_i.stb && !timer_busy;
	assign beat_last  = half_req_i.stb && timer_expired;

	wbx2_wait_timer timer_i (
		.clk_x2    (clk_x2),
		.reset     (reset),
		.start_i   (beat_start),
		.busy_o    (timer_busy),
		.expired_o (timer_expired)
	);

	// byte enables apply on the last beat cycle only
	always_ff @(posedge clk_x2) begin
		if (beat_last && half_req_i.we) begin
			for (int b = 0; b < BYTES; b++) begin
				if (half_req_i.sel[b]) begin
					mem_q[idx][b*8 +: 8] <= half_req_i.dat[b*8 +: 8];
				end
			end
		end
	end

	assign half_rsp_o.dat = mem_q[idx];
	assign half_rsp_o.ack = beat_last;

	// each beat acks exactly the wait states after it starts
	a_ack_after_wait_states: assert property (@(posedge clk_x2) disable iff (reset)
		beat_start |-> ##(`WBX2_WAIT_STATES) half_rsp_o.ack);

endmodule

/* hw/wbx2_lane_mux.sv */
`include "wbx2_params.svh"

module wbx2_lane_mux (
	input  logic                        clk_x2,
	input  logic                        reset,
	input  wbx2_pkg::endian_e           endian_i,
	input  wbx2_pkg::wb_wide_req_t      wide_req_i,
	input  logic                        beat_i,
	input  logic                        half_ack_i,
	input  logic [`WBX2_HALF_DAT_W-1:0] half_rdat_i,
	output wbx2_pkg::wb_half_req_t      half_req_o,
	output logic [1:0]                  beat_sel_o,
	output logic [`WBX2_WIDE_DAT_W-1:0] wide_rdat_o
);

	localparam int HW = `WBX2_HALF_DAT_W;
	localparam int HS = HW / 8;

	logic          upper_lane;
	logic [HW-1:0] beat0_rdat_q;
	logic [HW-1:0] beat1_rdat_q;

	// ------------------------------------------------
	// write side lane select
	// ------------------------------------------------
	// big endian puts the high half on beat 0
	assign upper_lane = beat_i ^ (endian_i == wbx2_pkg::ENDIAN_BIG);

	always_comb begin
		half_req_o.adr = {wide_req_i.adr, beat_i};
		half_req_o.dat = upper_lane ? wide_req_i.dat[HW +: HW] : wide_req_i.dat[0 +: HW];
		half_req_o.we  = wide_req_i.we;
		half_req_o.sel = upper_lane ? wide_req_i.sel[HS +: HS] : wide_req_i.sel[0 +: HS];
		// beat stb comes from the FSM
		half_req_o.stb = 1'b0;
	end

	assign beat_sel_o = half_req_o.sel;

	// ------------------------------------------------
	// read capture, one register per beat
	// ------------------------------------------------
	always_ff @(posedge clk_x2) begin
		if (reset) begin
			beat0_rdat_q <= '0;
			beat1_rdat_q <= '0;
		end else if (half_ack_i) begin
			if (beat_i) begin
				beat1_rdat_q <= half_rdat_i;
			end else begin
				beat0_rdat_q <= half_rdat_i;
			end
		end
	end

	// merged word holds still while the wide ack is up
	assign wide_rdat_o = (endian_i == wbx2_pkg::ENDIAN_BIG) ?
		{beat0_rdat_q, beat1_rdat_q} : {beat1_rdat_q, beat0_rdat_q};

endmodule

/* hw/wbx2_params.svh */
`ifndef WBX2_PARAMS_SVH
`define WBX2_PARAMS_SVH

// ------------------------------------------------
// slow side bus widths
// ------------------------------------------------
`define WBX2_WIDE_ADR_W 30
`define WBX2_WIDE_DAT_W 32

// half side data width
`define WBX2_HALF_DAT_W 16

// ------------------------------------------------
// half-width memory model
// ------------------------------------------------
`define WBX2_RAM_DEPTH 256
// extra cycles per beat, 0 to 3
`define WBX2_WAIT_STATES 1

`endif

/* hw/wbx2_pkg.sv */
`include "wbx2_params.svh"

package wbx2_pkg;

	// ------------------------------------------------
	// slow side port, one 32-bit access
	// ------------------------------------------------
	typedef struct packed {
		logic [`WBX2_WIDE_ADR_W-1:0]   adr;
		logic [`WBX2_WIDE_DAT_W-1:0]   dat;
		logic                          we;
		logic [`WBX2_WIDE_DAT_W/8-1:0] sel;
		logic                          stb;
	} wb_wide_req_t;

	typedef struct packed {
		logic [`WBX2_WIDE_DAT_W-1:0] dat;
		logic                        ack;
	} wb_wide_rsp_t;

	// ------------------------------------------------
	// half side port, one beat
	// ------------------------------------------------
	// half-word address, one bit wider than the word address
	typedef struct packed {
		logic [`WBX2_WIDE_ADR_W:0]     adr;
		logic [`WBX2_HALF_DAT_W-1:0]   dat;
		logic                          we;
		logic [`WBX2_HALF_DAT_W/8-1:0] sel;
		logic                          stb;
	} wb_half_req_t;

	typedef struct packed {
		logic [`WBX2_HALF_DAT_W-1:0] dat;
		logic                        ack;
	} wb_half_rsp_t;

	// lane order of the two halves
	typedef enum logic {
		ENDIAN_LITTLE = 1'b0,
		ENDIAN_BIG    = 1'b1
	} endian_e;

	typedef enum logic [1:0] {
		BEAT_IDLE   = 2'd0,
		BEAT_FIRST  = 2'd1,
		BEAT_SECOND = 2'd2,
		BEAT_HOLD   = 2'd3
	} beat_state_e;

endpackage

/* hw/wbx2_top.sv */
`include "wbx2_params.svh"

module wbx2_top (
	input  logic                   clk_x2,
	input  logic                   reset,
	input  wbx2_pkg::endian_e      endian_i,
	input  wbx2_pkg::wb_wide_req_t wide_req_i,
	output wbx2_pkg::wb_wide_rsp_t wide_rsp_o,
	output logic                   phase_o
);

	wbx2_pkg::wb_half_req_t      lane_req;
	wbx2_pkg::wb_half_req_t      half_req;
	wbx2_pkg::wb_half_rsp_t      half_rsp;
	logic                        beat;
	logic                        half_stb;
	logic                        wide_ack;
	logic [1:0]                  beat_sel;
	logic [`WBX2_WIDE_DAT_W-1:0] wide_rdat;

	wbx2_beat_fsm fsm_i (
		.clk_x2     (clk_x2),
		.reset      (reset),
		.wide_stb_i (wide_req_i.stb),
		.beat_sel_i (beat_sel),
		.half_ack_i (half_rsp.ack),
		.beat_o     (beat),
		.half_stb_o (half_stb),
		.wide_ack_o (wide_ack),
		.phase_o    (phase_o)
	);

	wbx2_lane_mux mux_i (
		.clk_x2      (clk_x2),
		.reset       (reset),
		.endian_i    (endian_i),
		.wide_req_i  (wide_req_i),
		.beat_i      (beat),
		.half_ack_i  (half_rsp.ack),
		.half_rdat_i (half_rsp.dat),
		.half_req_o  (lane_req),
		.beat_sel_o  (beat_sel),
		.wide_rdat_o (wide_rdat)
	);

	// ------------------------------------------------
	// beat request, lanes from the mux and stb from the FSM
	// ------------------------------------------------
	always_comb begin
		half_req     = lane_req;
		half_req.stb = half_stb;
	end

	wbx2_half_ram ram_i (
		.clk_x2     (clk_x2),
		.reset      (reset),
		.half_req_i (half_req),
		.half_rsp_o (half_rsp)
	);

	assign wide_rsp_o.dat = wide_rdat;
	assign wide_rsp_o.ack = wide_ack;

endmodule

/* hw/wbx2_wait_timer.sv */
`include "wbx2_params.svh"

module wbx2_wait_timer (
	input  logic clk_x2,
	input  logic reset,
	input  logic start_i,
	output logic busy_o,
	output logic expired_o
);

	localparam int CNT_W = (`WBX2_WAIT_STATES < 2) ? 1 : $clog2(`WBX2_WAIT_STATES + 1);
	localparam logic [CNT_W-1:0] LAST = CNT_W'(`WBX2_WAIT_STATES);

	logic             busy_q;
	logic [CNT_W-1:0] cnt_q;
	logic [CNT_W-1:0] elapsed;

	// cycles since start, zero in the start cycle itself
	assign elapsed   = busy_q ? cnt_q : '0;
	assign expired_o = (start_i || busy_q) && (elapsed == LAST);
	assign busy_o    = busy_q;

	always_ff @(posedge clk_x2) begin
		if (reset) begin
			busy_q <= 1'b0;
			cnt_q  <= '0;
		end else if (expired_o) begin
			busy_q <= 1'b0;
		end else if (busy_q) begin
			cnt_q <= cnt_q + 1'b1;
		end else if (start_i) begin
			busy_q <= 1'b1;
			cnt_q  <= CNT_W'(1);
		end
	end

endmodule

/* project.f */
+incdir+hw
hw/wbx2_pkg.sv
hw/wbx2_wait_timer.sv
hw/wbx2_half_ram.sv
hw/wbx2_beat_fsm.sv
hw/wbx2_lane_mux.sv
hw/wbx2_top.sv
dv/tb_clk_gen.sv
dv/tb_wbx2_top.sv
